//--- c1Pkg.sv
package c1Pkg;

	// upper address bits A23..A17, index 6 is A23
	typedef logic [6:0] m68kAddrT;

	// one data byte, upper half of the 68k bus
	typedef logic [7:0] byteT;

	// wait-state down counter
	typedef logic [1:0] waitCntT;

	// cpu side of the async bus, all strobes active low except rw
	typedef struct packed {
		m68kAddrT addr;
		logic     nAs;
		logic     nUds;
		logic     nLds;
		// high for read
		logic     rw;
	} cpuBusT;

	// zone selects, all active low
	typedef struct packed {
		logic rom;
		logic wram;
		logic port;
		logic io;
		// even-byte register sub-zones of io
		logic ctrl1;
		logic icom;
		logic ctrl2;
		logic statusB;
		logic lspc;
		logic pal;
		logic card;
		logic sRom;
		logic sRam;
	} zoneT;

	// chip strobes, all active low
	typedef struct packed {
		logic       romOeL;
		logic       romOeU;
		logic       sRomOeL;
		logic       sRomOeU;
		logic       lspOe;
		logic       lspWe;
		// memory card
		logic       crdO;
		logic       crdW;
		logic       crdC;
		// odd-byte io strobes
		logic       bitW0;
		logic       bitW1;
		logic       dipRd0;
		logic       dipRd1;
		// unused, held high
		logic [2:0] spare;
	} strobeT;

	// wait states per zone
	localparam waitCntT romWaitStates  = 2'd1;
	localparam waitCntT cardWaitStates = 2'd2;
	localparam waitCntT zeroWaitStates = 2'd0;

	// dtack fsm
	typedef enum logic [1:0] {
		waitIdle,
		waitCount,
		waitAck,
		waitRelease
	} waitStateT;

endpackage

//--- c1AddrDecode.sv
`timescale 1ns/10ps

module c1AddrDecode (
	input  c1Pkg::cpuBusT bus,
	output c1Pkg::zoneT   zones,
	output c1Pkg::strobeT strobes
);
	import c1Pkg::*;

	m68kAddrT addr;
	logic     a23;
	logic     a22;
	logic     a21;
	logic     a20;
	logic     a19;
	logic     a18;
	logic     a17;
	// io zone, 0x3xxxxx
	logic     nIoZone;
	// even-byte access inside io
	logic     nC1Regs;
	// both data strobes low
	logic     nWordAccess;

	assign addr = bus.addr;
	assign {a23, a22, a21, a20, a19, a18, a17} = addr;

	assign nIoZone     = a23 | a22 | ~a21 | ~a20;
	assign nC1Regs     = bus.nUds | nIoZone;
	assign nWordAccess = bus.nLds | bus.nUds;

	always_comb begin
		// 0x0xxxxx program rom
		zones.rom  = a23 | a22 | a21 | a20;
		// 0x1xxxxx work ram
		zones.wram = a23 | a22 | a21 | ~a20;
		// 0x2xxxxx cartridge port
		zones.port = a23 | a22 | ~a21 | a20;
		zones.io   = nIoZone;

		// 30/31 even, read only
		zones.ctrl1 = nC1Regs | ~bus.rw | a19 | a18 | a17;
		// 32/33 even, read and write
		zones.icom = nC1Regs | a19 | a18 | ~a17;
		// 34..37 even, read only; a17 not decoded
		zones.ctrl2 = nC1Regs | ~bus.rw | a19 | ~a18;
		// 38/39 even, read only
		zones.statusB = nC1Regs | ~bus.rw | ~a19 | a18 | a17;
		// 3c/3d, both bytes
		zones.lspc = nIoZone | ~a19 | ~a18 | a17;

		// 0x4..0x7 palette
		zones.pal  = a23 | ~a22;
		// 0x8..0xb memory card
		zones.card = ~a23 | a22;
		// 0xc system rom
		zones.sRom = ~a23 | ~a22 | a21 | a20;
		// 0xd backup ram
		zones.sRam = ~a23 | ~a22 | a21 | ~a20;
	end

	always_comb begin
		// rom reads, per byte lane
		strobes.romOeL  = ~bus.rw | bus.nLds | zones.rom | bus.nAs;
		strobes.romOeU  = ~bus.rw | bus.nUds | zones.rom | bus.nAs;
		strobes.sRomOeL = ~bus.rw | bus.nLds | zones.sRom | bus.nAs;
		strobes.sRomOeU = ~bus.rw | bus.nUds | zones.sRom | bus.nAs;

		// lspc only on word access
		strobes.lspOe = ~bus.rw | nWordAccess | zones.lspc | bus.nAs;
		strobes.lspWe = bus.rw | nWordAccess | zones.lspc | bus.nAs;

		// card, word access too
		strobes.crdO = ~bus.rw | nWordAccess | zones.card | bus.nAs;
		strobes.crdW = bus.rw | nWordAccess | zones.card | bus.nAs;
		// chip enable on either direction
		strobes.crdC = strobes.crdO & strobes.crdW;

		// 38/39 odd, write only
		strobes.bitW0 = bus.nLds | bus.rw | nIoZone | ~a19 | a18 | a17;
		// 3a/3b odd, write only
		strobes.bitW1 = bus.nLds | bus.rw | nIoZone | ~a19 | a18 | ~a17;
		// 30/31 odd, dip read
		strobes.dipRd0 = bus.nLds | ~bus.rw | nIoZone | a19 | a18 | a17;
		// 32/33 odd, second dip bank
		strobes.dipRd1 = bus.nLds | ~bus.rw | nIoZone | a19 | a18 | ~a17;

		strobes.spare = 3'b111;
	end

endmodule

//--- c1WaitGen.sv
`timescale 1ns/10ps

module c1WaitGen (
	input  logic        clk68kClk,
	input  logic        rstN,
	input  logic        nAs,
	input  c1Pkg::zoneT zones,
	input  logic        nRomWait,
	input  logic        nPWait0,
	input  logic        nPWait1,
	input  logic        pDtack,
	output logic        nDtack
);
	import c1Pkg::*;

	waitStateT state;
	waitCntT   cnt;
	waitCntT   loadCnt;
	waitCntT   portWaits;
	// some zone of the map is hit
	logic      mapped;

	// one wait per low port-wait pin
	assign portWaits = {1'b0, ~nPWait0} + {1'b0, ~nPWait1};

	// 0xe and 0xf decode to nothing
	assign mapped = ~&{zones.rom, zones.wram, zones.port, zones.io,
		zones.pal, zones.card, zones.sRom, zones.sRam};

	always_comb begin
		if (!zones.card) begin
			loadCnt = cardWaitStates;
		end else if (!zones.rom) begin
			loadCnt = nRomWait ? zeroWaitStates : romWaitStates;
		end else if (!zones.port) begin
			// cartridge dtack overrides the wait pins
			loadCnt = pDtack ? portWaits : zeroWaitStates;
		end else begin
			loadCnt = zeroWaitStates;
		end
	end

	always_ff @(posedge clk68kClk) begin
		if (!rstN) begin
			state <= waitIdle;
			cnt   <= '0;
		end else begin
			case (state)
				waitIdle: begin
					// unmapped cycles stay here, cpu times out
					if (!nAs && mapped) begin
						cnt   <= loadCnt;
						state <= waitCount;
					end
				end
				waitCount: begin
					// aborted cycle
					if (nAs) begin
						state <= waitIdle;
					end else if (cnt == '0) begin
						state <= waitAck;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				waitAck: begin
					// hold dtack while cpu holds as
					if (nAs) begin
						state <= waitRelease;
					end
				end
				waitRelease: begin
					state <= waitIdle;
				end
				default: begin
					state <= waitIdle;
				end
			endcase
		end
	end

	// low through ack and the release edge
	assign nDtack = !(state == waitAck || state == waitRelease);

endmodule

//--- c1CommLatch.sv
`timescale 1ns/10ps

module c1CommLatch (
	input  logic        clk68kClk,
	input  logic        rstN,
	input  logic        nAs,
	input  logic        rw,
	input  logic        icomSel,
	input  c1Pkg::byteT m68kDataIn,
	input  c1Pkg::byteT sdd,
	output c1Pkg::byteT soundCmd,
	output logic        nSdw,
	output c1Pkg::byteT reply
);

	// as from the previous edge
	logic nAsQ;
	// first edge of an icom write
	logic load;

	// icomSel already carries the upper data strobe
	assign load = !nAs && nAsQ && !icomSel && !rw;

	always_ff @(posedge clk68kClk) begin
		if (!rstN) begin
			nAsQ     <= 1'b1;
			nSdw     <= 1'b1;
			soundCmd <= '0;
		end else begin
			nAsQ <= nAs;
			// one-cycle pulse to the sound cpu
			nSdw <= !load;
			if (load) begin
				soundCmd <= m68kDataIn;
			end
		end
	end

	// sound cpu reply byte, read back through icom
	assign reply = sdd;

endmodule

//--- c1InputMux.sv
`timescale 1ns/10ps

module c1InputMux (
	input  c1Pkg::zoneT zones,
	input  c1Pkg::byteT p1In,
	input  c1Pkg::byteT p2In,
	input  c1Pkg::byteT dipSw,
	input  c1Pkg::byteT reply,
	input  logic        nCd1,
	input  logic        nCd2,
	input  logic        nWp,
	output c1Pkg::byteT m68kDataOut
);
	import c1Pkg::*;

	// card sense on top, dips below
	byteT statusByte;

	assign statusByte = {nWp, nCd2, nCd1, dipSw[4:0]};

	// zones are exclusive, order does not matter
	always_comb begin
		if (!zones.ctrl1) begin
			m68kDataOut = p1In;
		end else if (!zones.ctrl2) begin
			m68kDataOut = p2In;
		end else if (!zones.icom) begin
			m68kDataOut = reply;
		end else if (!zones.statusB) begin
			m68kDataOut = statusByte;
		end else begin
			// floating bus reads high
			m68kDataOut = '1;
		end
	end

endmodule

//--- neoC1.sv
`timescale 1ns/10ps

module neoC1 (
	input  logic          clk68kClk,
	input  logic          rstN,
	input  c1Pkg::cpuBusT bus,
	input  c1Pkg::byteT   m68kDataIn,
	input  c1Pkg::byteT   p1In,
	input  c1Pkg::byteT   p2In,
	input  c1Pkg::byteT   dipSw,
	input  logic          nCd1,
	input  logic          nCd2,
	input  logic          nWp,
	input  logic          nRomWait,
	input  logic          nPWait0,
	input  logic          nPWait1,
	input  logic          pDtack,
	input  c1Pkg::byteT   sdd,
	output c1Pkg::zoneT   zones,
	output c1Pkg::strobeT strobes,
	output c1Pkg::byteT   m68kDataOut,
	output logic          dataOe,
	output c1Pkg::byteT   soundCmd,
	output logic          nSdw,
	output logic          nDtack
);
	import c1Pkg::*;

	// sound reply toward the read mux
	byteT reply;
	// any register zone that drives the data bus
	logic readZone;

	c1AddrDecode c1AddrDecode_inst (
		.bus     (bus),
		.zones   (zones),
		.strobes (strobes)
	);

	c1WaitGen c1WaitGen_inst (
		.clk68kClk (clk68kClk),
		.rstN      (rstN),
		.nAs       (bus.nAs),
		.zones     (zones),
		.nRomWait  (nRomWait),
		.nPWait0   (nPWait0),
		.nPWait1   (nPWait1),
		.pDtack    (pDtack),
		.nDtack    (nDtack)
	);

	c1CommLatch c1CommLatch_inst (
		.clk68kClk  (clk68kClk),
		.rstN       (rstN),
		.nAs        (bus.nAs),
		.rw         (bus.rw),
		.icomSel    (zones.icom),
		.m68kDataIn (m68kDataIn),
		.sdd        (sdd),
		.soundCmd   (soundCmd),
		.nSdw       (nSdw),
		.reply      (reply)
	);

	c1InputMux c1InputMux_inst (
		.zones       (zones),
		.p1In        (p1In),
		.p2In        (p2In),
		.dipSw       (dipSw),
		.reply       (reply),
		.nCd1        (nCd1),
		.nCd2        (nCd2),
		.nWp         (nWp),
		.m68kDataOut (m68kDataOut)
	);

	// icom is read/write, so rw gates it here
	assign readZone = !zones.icom || !zones.ctrl1 || !zones.ctrl2 || !zones.statusB;
	assign dataOe   = !bus.nAs && bus.rw && readZone;

endmodule

//--- tbBusTasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// zone map: upper nibble picks the zone, a19..a17 the io register
function automatic zoneT refZones(cpuBusT b);
	zoneT       z;
	logic [3:0] nib;
	logic [2:0] sub;
	logic       evenIo;
	nib = b.addr[6:3];
	sub = b.addr[2:0];
	evenIo = (nib == 4'h3) && !b.nUds;
	z.rom = (nib != 4'h0);
	z.wram = (nib != 4'h1);
	z.port = (nib != 4'h2);
	z.io = (nib != 4'h3);
	// read-only registers need rw high
	z.ctrl1 = !(evenIo && b.rw && sub == 3'd0);
	z.icom = !(evenIo && sub == 3'd1);
	z.ctrl2 = !(evenIo && b.rw && (sub == 3'd2 || sub == 3'd3));
	z.statusB = !(evenIo && b.rw && sub == 3'd4);
	z.lspc = !(nib == 4'h3 && sub == 3'd6);
	z.pal = !(nib >= 4'h4 && nib <= 4'h7);
	z.card = !(nib >= 4'h8 && nib <= 4'hb);
	z.sRom = (nib != 4'hc);
	z.sRam = (nib != 4'hd);
	return z;
endfunction

// chip strobes, memory strobes qualified by nAs
function automatic strobeT refStrobes(cpuBusT b);
	strobeT     s;
	zoneT       z;
	logic       rd;
	logic       wr;
	logic       word;
	logic       oddIo;
	logic [2:0] sub;
	z = refZones(b);
	sub = b.addr[2:0];
	rd = !b.nAs && b.rw;
	wr = !b.nAs && !b.rw;
	word = !b.nUds && !b.nLds;
	oddIo = !z.io && !b.nLds;
	s.romOeL = !(rd && !b.nLds && !z.rom);
	s.romOeU = !(rd && !b.nUds && !z.rom);
	s.sRomOeL = !(rd && !b.nLds && !z.sRom);
	s.sRomOeU = !(rd && !b.nUds && !z.sRom);
	s.lspOe = !(rd && word && !z.lspc);
	s.lspWe = !(wr && word && !z.lspc);
	s.crdO = !(rd && word && !z.card);
	s.crdW = !(wr && word && !z.card);
	s.crdC = !(!b.nAs && word && !z.card);
	// odd-byte io, no nAs
	s.bitW0 = !(oddIo && !b.rw && sub == 3'd4);
	s.bitW1 = !(oddIo && !b.rw && sub == 3'd5);
	s.dipRd0 = !(oddIo && b.rw && sub == 3'd0);
	s.dipRd1 = !(oddIo && b.rw && sub == 3'd1);
	s.spare = 3'b111;
	return s;
endfunction

// start of a cycle, nAs low from this edge on
task automatic driveBus(m68kAddrT address, logic rw, logic nUds, logic nLds);
	@(posedge clk68kClk);
	bus <= '{addr: address, nAs: 1'b0, nUds: nUds, nLds: nLds, rw: rw};
endtask

task automatic releaseBus();
	@(posedge clk68kClk);
	bus.nAs  <= 1'b1;
	bus.nUds <= 1'b1;
	bus.nLds <= 1'b1;
endtask

// edges after the one that first samples the new nAs, until nDtack reaches level
task automatic edgesUntilDtack(logic level, output int latency);
	int edges;
	edges = 0;
	do begin
		@(posedge clk68kClk);
		@(negedge clk68kClk);
		edges++;
		if (edges > 12) begin
			stopOnTimeout("nDtack never reached the expected level");
		end
	end while (nDtack !== level);
	latency = edges - 1;
endtask

`endif

//--- tbNeoC1.sv
`timescale 1ns/10ps

module tbNeoC1;
	import c1Pkg::*;

	logic        clk68kClk;
	logic        rstN;
	cpuBusT      bus;
	byteT        m68kDataIn;
	byteT        p1In;
	byteT        p2In;
	byteT        dipSw;
	logic        nCd1;
	logic        nCd2;
	logic        nWp;
	logic        nRomWait;
	logic        nPWait0;
	logic        nPWait1;
	logic        pDtack;
	byteT        sdd;
	zoneT        zones;
	strobeT      strobes;
	byteT        m68kDataOut;
	logic        dataOe;
	byteT        soundCmd;
	logic        nSdw;
	logic        nDtack;
	// scratch for the stimulus
	logic [31:0] r;
	byteT        cmd;
	int          lowCount;
	int          lat;

	`include "tbBusTasks.svh"

	neoC1 neoC1_inst (.*);

	initial begin
		clk68kClk = 1'b0;
		forever #4 clk68kClk = ~clk68kClk;
	end

	task automatic checkEqual(string name, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic stopOnTimeout(string what);
		$display("Timeout: %s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	// write strobe to the sound cpu is a single cycle
	assert property (@(posedge clk68kClk) disable iff (!rstN) !nSdw |=> nSdw)
	else begin
		$display("Fail nSdw pulse width: expected 1, actual 0");
		$display("Test failed");
		$fatal(1);
	end

	// the controller never drives data during a write
	assert property (@(posedge clk68kClk) !bus.rw |-> !dataOe)
	else begin
		$display("Fail dataOe on write: expected 0, actual 1");
		$display("Test failed");
		$fatal(1);
	end

	// wait states from the bus rules and the current wait pins
	function automatic int waitsFor(logic [3:0] nibble);
		if (nibble >= 4'h8 && nibble <= 4'hb) begin
			return 2;
		end else if (nibble == 4'h0) begin
			return nRomWait ? 0 : 1;
		end else if (nibble == 4'h2 && pDtack) begin
			return (nPWait0 ? 0 : 1) + (nPWait1 ? 0 : 1);
		end
		return 0;
	endfunction

	task automatic setWaitPins(logic romW, logic pw0, logic pw1, logic pd);
		@(posedge clk68kClk);
		nRomWait <= romW;
		nPWait0  <= pw0;
		nPWait1  <= pw1;
		pDtack   <= pd;
		@(negedge clk68kClk);
	endtask

	// one read cycle, nAs held a few random edges past dtack
	task automatic checkLatency(string name, m68kAddrT address);
		int waits;
		int ackLat;
		int hold;
		waits = waitsFor(address[6:3]);
		hold = $urandom_range(3, 0);
		driveBus(address, 1'b1, 1'b0, 1'b0);
		edgesUntilDtack(1'b0, ackLat);
		checkEqual({name, " ack"}, 1 + waits, ackLat);
		repeat (hold) begin
			@(negedge clk68kClk);
			checkEqual({name, " hold"}, 0, {31'd0, nDtack});
		end
		releaseBus();
		edgesUntilDtack(1'b1, ackLat);
		checkEqual({name, " release"}, 1, ackLat);
	endtask

	task automatic readRegister(string name, m68kAddrT address, byteT expected, logic oe);
		int rdLat;
		driveBus(address, 1'b1, 1'b0, 1'b1);
		@(negedge clk68kClk);
		checkEqual({name, " dataOe"}, {31'd0, oe}, {31'd0, dataOe});
		if (oe) begin
			checkEqual({name, " data"}, {24'd0, expected}, {24'd0, m68kDataOut});
		end
		edgesUntilDtack(1'b0, rdLat);
		releaseBus();
		edgesUntilDtack(1'b1, rdLat);
	endtask

	initial begin
		r = $urandom(32'h30a5);
		rstN       <= 1'b0;
		bus        <= '{addr: '0, nAs: 1'b1, nUds: 1'b1, nLds: 1'b1, rw: 1'b1};
		m68kDataIn <= '0;
		p1In       <= '0;
		p2In       <= '0;
		dipSw      <= '0;
		sdd        <= '0;
		nCd1       <= 1'b1;
		nCd2       <= 1'b1;
		nWp        <= 1'b1;
		nRomWait   <= 1'b1;
		nPWait0    <= 1'b1;
		nPWait1    <= 1'b1;
		pDtack     <= 1'b1;
		repeat (2) @(posedge clk68kClk);
		rstN <= 1'b1;

		@(negedge clk68kClk);
		checkEqual("reset nDtack", 1, {31'd0, nDtack});
		checkEqual("reset nSdw", 1, {31'd0, nSdw});
		checkEqual("reset soundCmd", 0, {24'd0, soundCmd});

		// random bus values against the reference map
		for (int i = 0; i < 200; i++) begin
			@(posedge clk68kClk);
			r = $urandom;
			bus <= cpuBusT'(r[10:0]);
			@(negedge clk68kClk);
			checkEqual("decode zones", {19'd0, refZones(bus)}, {19'd0, zones});
			checkEqual("decode strobes", {16'd0, refStrobes(bus)}, {16'd0, strobes});
		end
		releaseBus();
		repeat (3) @(posedge clk68kClk);

		// dtack latency per zone
		r = $urandom;
		setWaitPins(1'b1, 1'b1, 1'b1, 1'b1);
		checkLatency("rom no wait", {4'h0, r[2:0]});
		for (int p = 0; p < 4; p++) begin
			setWaitPins(1'b1, p[0], p[1], 1'b1);
			checkLatency("port wait pins", {4'h2, r[5:3]});
		end
		// cartridge dtack wins over both wait pins
		setWaitPins(1'b1, 1'b0, 1'b0, 1'b0);
		checkLatency("port pDtack", {4'h2, r[8:6]});
		setWaitPins(1'b0, 1'b1, 1'b1, 1'b1);
		checkLatency("rom wait", {4'h0, r[11:9]});
		checkLatency("card", {2'b10, r[13:12], r[16:14]});
		checkLatency("wram", {4'h1, r[19:17]});

		driveBus({4'he, r[22:20]}, 1'b1, 1'b0, 1'b0);
		repeat (10) begin
			@(negedge clk68kClk);
			checkEqual("unmapped no ack", 1, {31'd0, nDtack});
		end
		releaseBus();
		repeat (2) @(posedge clk68kClk);

		// sound command, upper byte write to 0x32xxxx
		r = $urandom;
		cmd = r[7:0];
		driveBus({4'h3, 3'b001}, 1'b0, 1'b0, 1'b1);
		m68kDataIn <= cmd;
		lowCount = 0;
		// nAs held, data changes after the first edge
		repeat (8) begin
			@(posedge clk68kClk);
			m68kDataIn <= ~cmd;
			@(negedge clk68kClk);
			checkEqual("sound write dataOe", 0, {31'd0, dataOe});
			if (!nSdw) begin
				lowCount++;
			end
		end
		checkEqual("sound nSdw pulses", 1, lowCount);
		checkEqual("sound soundCmd", {24'd0, cmd}, {24'd0, soundCmd});
		checkEqual("sound dtack held", 0, {31'd0, nDtack});
		releaseBus();
		edgesUntilDtack(1'b1, lat);

		// register reads
		@(posedge clk68kClk);
		r = $urandom;
		p1In  <= r[7:0];
		p2In  <= r[15:8];
		dipSw <= r[23:16];
		sdd   <= r[31:24];
		r = $urandom;
		nCd1 <= r[0];
		nCd2 <= r[1];
		nWp  <= r[2];
		@(negedge clk68kClk);
		readRegister("ctrl1", {4'h3, 3'b000}, p1In, 1'b1);
		readRegister("ctrl2", {4'h3, 3'b011}, p2In, 1'b1);
		// card sense replaces the top three dip bits
		readRegister("statusB", {4'h3, 3'b100}, {nWp, nCd2, nCd1, dipSw[4:0]}, 1'b1);
		readRegister("icom", {4'h3, 3'b001}, sdd, 1'b1);
		readRegister("rom", {4'h0, r[5:3]}, 8'h00, 1'b0);

		$display("Test passed");
		$finish;
	end

endmodule

//--- files.f
+incdir+.
c1Pkg.sv
c1AddrDecode.sv
c1WaitGen.sv
c1CommLatch.sv
c1InputMux.sv
neoC1.sv
tbNeoC1.sv

//--- run.sh
#!/bin/sh
# build and run with verilator, pass is decided from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tbNeoC1 -f files.f -o simNeoC1 \
	&& ./obj_dir/simNeoC1 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test passed" sim.log 2>/dev/null && echo "simulation ok" || { echo "simulation failed"; exit 1; }
